// ==== common/pod_cfg_pkg.sv ====
////////////////////////////////////////////////////////////
// Pod datapath configuration
// Lane count, buffer sizes, fill thresholds and burst length
// for the memory side of one logic analyzer pod
////////////////////////////////////////////////////////////

package pod_cfg_pkg;

	// Lane geometry
	localparam int num_lanes = 8;
	localparam int lane_bits = 3;
	localparam int word_bits = 128;

	// Words moved per arbitration grant
	localparam int burst_len  = 4;
	localparam int phase_bits = $clog2(burst_len + 1);

	// Buffer depths and the priority threshold
	localparam int lane_depth = 64;
	localparam int lane_half  = 32;
	localparam int data_depth = 64;
	localparam int addr_depth = 16;

	// Fill count widths, one extra bit so a full buffer is representable
	localparam int lane_cnt_bits = $clog2(lane_depth) + 1;
	localparam int data_cnt_bits = $clog2(data_depth) + 1;
	localparam int addr_cnt_bits = $clog2(addr_depth) + 1;

	// One lane's write port
	typedef struct packed {
		logic                 wr;
		logic [word_bits-1:0] data;
	} lane_req_t;

	// Per-lane fill flags seen by the arbiter
	typedef struct packed {
		logic [num_lanes-1:0] half_full;
		logic [num_lanes-1:0] burst_ready;
	} lane_status_t;

endpackage

// ==== common/ram_req_pkg.sv ====
////////////////////////////////////////////////////////////
// RAM request words
// Layout of the 29-bit burst address word sent to the
// memory controller
////////////////////////////////////////////////////////////

package ram_req_pkg;

	// Per-lane burst pointer, 2^22 bursts of storage per lane
	localparam int ptr_bits  = 22;
	localparam int pad_bits  = 2;
	localparam int addr_bits = 29;

	// Field view, MSB first
	typedef struct packed {
		logic                               valid;
		logic                               pod;
		logic [pod_cfg_pkg::lane_bits-1:0]  lane;
		logic [ptr_bits-1:0]                ptr;
		// Low bits select the word within a burst, always zero here
		logic [pad_bits-1:0]                pad;
	} ram_addr_fields_t;

	// Built by fields in the writer, stored and moved as a raw word
	typedef union packed {
		ram_addr_fields_t      fields;
		logic [addr_bits-1:0]  raw;
	} ram_addr_t;

endpackage

// ==== logic/sample_fifo.sv ====
////////////////////////////////////////////////////////////
// Single-clock FIFO
// Circular buffer with a registered read port, reporting
// free slots and fill count
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sample_fifo #(
	parameter int width = 8,
	parameter int depth = 16
) (
	input  logic                       clk_ram_2x,
	input  logic                       rst,
	input  logic                       wr,
	input  logic [width-1:0]           din,
	input  logic                       rd,
	output logic [width-1:0]           dout,
	output logic [$clog2(depth):0]     wsize,
	output logic [$clog2(depth):0]     rsize
);

	// Depth must be a power of two so the pointers wrap by themselves
	localparam int ptr_w = $clog2(depth);
	localparam int cnt_w = ptr_w + 1;

	logic [width-1:0] mem [depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;

	// Qualified strobes, overflow and underflow are dropped
	logic wr_ok;
	logic rd_ok;

	assign wr_ok = wr && (count != cnt_w'(depth));
	assign rd_ok = rd && (count != '0);

	////////////////////////////////////////////////////////////
	// Pointers and fill count

	always_ff @(posedge clk_ram_2x) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_ok)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_ok)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_ok, rd_ok})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Storage and registered read port

	always_ff @(posedge clk_ram_2x) begin
		if (wr_ok)
			mem[wr_ptr] <= din;
		// Word shows up on dout the cycle after rd
		if (rd_ok)
			dout <= mem[rd_ptr];
	end

	assign rsize = count;
	assign wsize = cnt_w'(depth) - count;

endmodule

// ==== arbiter/burst_arbiter.sv ====
////////////////////////////////////////////////////////////
// Burst arbiter
// Picks one capture lane per burst by fill priority and
// sequences the four pop phases
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module burst_arbiter (
	input  logic                                   clk_ram_2x,
	input  logic                                   rst,
	input  logic                                   ram_ready,
	input  pod_cfg_pkg::lane_status_t              lane_status,
	input  logic [pod_cfg_pkg::data_cnt_bits-1:0]  data_free,
	input  logic [pod_cfg_pkg::addr_cnt_bits-1:0]  addr_free,
	output logic [pod_cfg_pkg::num_lanes-1:0]      lane_rd,
	output logic                                   burst_start,
	output logic [pod_cfg_pkg::lane_bits-1:0]      burst_lane
);

	import pod_cfg_pkg::*;

	// 0 is idle, 1 to burst_len are the pop phases
	logic [phase_bits-1:0] phase;

	// Result of the priority search
	logic                  hit;
	logic [lane_bits-1:0]  pick;
	logic                  can_start;

	////////////////////////////////////////////////////////////
	// Lane selection

	always_comb begin
		hit  = 1'b0;
		pick = '0;

		// First pass, highest lane past the half-full mark
		for (int i = 0; i < num_lanes; i++) begin
			if (lane_status.half_full[i]) begin
				hit  = 1'b1;
				pick = lane_bits'(i);
			end
		end

		// Second pass, highest lane with at least a whole burst
		if (!hit) begin
			for (int i = 0; i < num_lanes; i++) begin
				if (lane_status.burst_ready[i]) begin
					hit  = 1'b1;
					pick = lane_bits'(i);
				end
			end
		end
	end

	// Only start from idle, armed, and with room for the whole burst
	assign can_start = (phase == '0) && ram_ready &&
		(data_free > data_cnt_bits'(burst_len)) && (addr_free != '0);

	////////////////////////////////////////////////////////////
	// Phase sequencing

	always_ff @(posedge clk_ram_2x) begin
		if (rst) begin
			phase      <= '0;
			burst_lane <= '0;
		end else if (phase == '0) begin
			// Choice is registered, burst begins next cycle
			if (can_start && hit) begin
				phase      <= phase_bits'(1);
				burst_lane <= pick;
			end
		end else if (phase == phase_bits'(burst_len)) begin
			// Last pop, fall back to idle for one cycle
			phase <= '0;
		end else begin
			phase <= phase + 1'b1;
		end
	end

	// First pop phase doubles as the start pulse
	assign burst_start = (phase == phase_bits'(1));

	// Chosen lane is popped on every non-idle phase
	always_comb begin
		lane_rd = '0;
		if (phase != '0)
			lane_rd[burst_lane] = 1'b1;
	end

endmodule

// ==== arbiter/burst_writer.sv ====
////////////////////////////////////////////////////////////
// Burst writer
// Moves popped lane words into the data FIFO and builds one
// address word per burst from per-lane pointers
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module burst_writer #(
	parameter int pod_number = 0
) (
	input  logic                                 clk_ram_2x,
	input  logic                                 rst,
	input  logic [pod_cfg_pkg::num_lanes-1:0]    lane_rd,
	input  logic                                 burst_start,
	input  logic [pod_cfg_pkg::lane_bits-1:0]    burst_lane,
	input  logic [pod_cfg_pkg::word_bits-1:0]    lane_dout [pod_cfg_pkg::num_lanes],
	output logic                                 data_wr,
	output logic [pod_cfg_pkg::word_bits-1:0]    data_word,
	output logic                                 addr_wr,
	output ram_req_pkg::ram_addr_t               addr_word
);

	import pod_cfg_pkg::*;
	import ram_req_pkg::*;

	// Pop pipeline, lines up with the lane FIFO read latency
	logic                  rd_valid;
	logic [lane_bits-1:0]  rd_lane;

	// Next burst slot in RAM for each lane
	logic [ptr_bits-1:0]   wr_ptr [num_lanes];

	////////////////////////////////////////////////////////////
	// Control path

	always_ff @(posedge clk_ram_2x) begin
		if (rst) begin
			rd_valid <= 1'b0;
			rd_lane  <= '0;
			data_wr  <= 1'b0;
			addr_wr  <= 1'b0;
			for (int i = 0; i < num_lanes; i++)
				wr_ptr[i] <= '0;
		end else begin
			rd_valid <= |lane_rd;
			rd_lane  <= burst_lane;
			// Data lands two cycles after its pop
			data_wr  <= rd_valid;
			// Address word goes out one cycle after the start pulse
			addr_wr  <= burst_start;
			if (burst_start)
				wr_ptr[burst_lane] <= wr_ptr[burst_lane] + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Payload path

	always_ff @(posedge clk_ram_2x) begin
		// Lane mux, second pipeline stage
		data_word <= lane_dout[rd_lane];

		if (burst_start) begin
			addr_word.fields.valid <= 1'b1;
			addr_word.fields.pod   <= 1'(pod_number);
			addr_word.fields.lane  <= burst_lane;
			// Pointer before the bump
			addr_word.fields.ptr   <= wr_ptr[burst_lane];
			addr_word.fields.pad   <= '0;
		end
	end

endmodule

// ==== logic/pod_ram_datapath.sv ====
////////////////////////////////////////////////////////////
// Pod RAM datapath
// Eight lane buffers arbitrated into burst-wide data and
// address FIFOs for the memory controller
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module pod_ram_datapath #(
	parameter int pod_number = 0
) (
	input  logic                                   clk_ram_2x,
	input  logic                                   rst,
	input  logic                                   ram_ready,
	input  pod_cfg_pkg::lane_req_t                 lane_in [pod_cfg_pkg::num_lanes],
	input  logic                                   ram_data_rd_en,
	output logic [pod_cfg_pkg::word_bits-1:0]      ram_data_rd_data,
	output logic [pod_cfg_pkg::data_cnt_bits-1:0]  ram_data_rd_size,
	input  logic                                   ram_addr_rd_en,
	output ram_req_pkg::ram_addr_t                 ram_addr_rd_data,
	output logic [pod_cfg_pkg::addr_cnt_bits-1:0]  ram_addr_rd_size
);

	import pod_cfg_pkg::*;
	import ram_req_pkg::*;

	logic [num_lanes-1:0]      lane_rd;
	logic [word_bits-1:0]      lane_dout [num_lanes];
	logic [lane_cnt_bits-1:0]  lane_cnt [num_lanes];
	lane_status_t              lane_status;

	logic                      burst_start;
	logic [lane_bits-1:0]      burst_lane;
	logic                      data_wr;
	logic [word_bits-1:0]      data_word;
	logic                      addr_wr;
	ram_addr_t                 addr_word;
	logic [data_cnt_bits-1:0]  data_free;
	logic [addr_cnt_bits-1:0]  addr_free;

	////////////////////////////////////////////////////////////
	// Lane buffers and fill flags

	for (genvar k = 0; k < num_lanes; k++) begin : g_lane
		sample_fifo #(
			.width(word_bits),
			.depth(lane_depth)
		) lane_fifo (
			.clk_ram_2x(clk_ram_2x),
			.rst(rst),
			.wr(lane_in[k].wr),
			.din(lane_in[k].data),
			.rd(lane_rd[k]),
			.dout(lane_dout[k]),
			.wsize(),
			.rsize(lane_cnt[k])
		);

		// Straight from the counts so a pop is seen the next cycle
		assign lane_status.half_full[k]   = lane_cnt[k] > lane_cnt_bits'(lane_half);
		assign lane_status.burst_ready[k] = lane_cnt[k] >= lane_cnt_bits'(burst_len);
	end

	////////////////////////////////////////////////////////////
	// Arbitration and burst assembly

	burst_arbiter arbiter (
		.clk_ram_2x(clk_ram_2x),
		.rst(rst),
		.ram_ready(ram_ready),
		.lane_status(lane_status),
		.data_free(data_free),
		.addr_free(addr_free),
		.lane_rd(lane_rd),
		.burst_start(burst_start),
		.burst_lane(burst_lane)
	);

	burst_writer #(
		.pod_number(pod_number)
	) writer (
		.clk_ram_2x(clk_ram_2x),
		.rst(rst),
		.lane_rd(lane_rd),
		.burst_start(burst_start),
		.burst_lane(burst_lane),
		.lane_dout(lane_dout),
		.data_wr(data_wr),
		.data_word(data_word),
		.addr_wr(addr_wr),
		.addr_word(addr_word)
	);

	////////////////////////////////////////////////////////////
	// Output FIFOs toward the memory controller

	sample_fifo #(
		.width(word_bits),
		.depth(data_depth)
	) data_fifo (
		.clk_ram_2x(clk_ram_2x),
		.rst(rst),
		.wr(data_wr),
		.din(data_word),
		.rd(ram_data_rd_en),
		.dout(ram_data_rd_data),
		.wsize(data_free),
		.rsize(ram_data_rd_size)
	);

	// Address words are kept as raw bits
	sample_fifo #(
		.width(addr_bits),
		.depth(addr_depth)
	) addr_fifo (
		.clk_ram_2x(clk_ram_2x),
		.rst(rst),
		.wr(addr_wr),
		.din(addr_word.raw),
		.rd(ram_addr_rd_en),
		.dout(ram_addr_rd_data),
		.wsize(addr_free),
		.rsize(ram_addr_rd_size)
	);

endmodule

// ==== verification/pod_ram_checker.sv ====
////////////////////////////////////////////////////////////
// Burst arbiter checker
// Concurrent properties on burst sequencing, bound into
// every burst_arbiter instance
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module pod_ram_checker (
	input logic                                clk_ram_2x,
	input logic                                rst,
	input logic                                ram_ready,
	input logic [pod_cfg_pkg::num_lanes-1:0]   lane_rd,
	input logic                                burst_start
);

	// Four one-hot pops from the start pulse on and one idle cycle after them
	pops_one_hot: assert property (@(posedge clk_ram_2x) disable iff (rst)
		burst_start |-> $onehot(lane_rd) ##1 $onehot(lane_rd) ##1 $onehot(lane_rd)
			##1 $onehot(lane_rd) ##1 (lane_rd == '0))
		else $error("lane_rd not one-hot for a whole burst");

	// Registered start decision means arming is checked one cycle back
	start_when_armed: assert property (@(posedge clk_ram_2x) disable iff (rst)
		burst_start |-> $past(ram_ready))
		else $error("burst started while ram_ready was low");

	// No pop may be running in the cycle before a new start
	start_when_idle: assert property (@(posedge clk_ram_2x) disable iff (rst)
		burst_start |-> ($past(lane_rd) == '0))
		else $error("burst started while the arbiter was busy");

endmodule

bind burst_arbiter pod_ram_checker arbiter_chk (
	.clk_ram_2x(clk_ram_2x),
	.rst(rst),
	.ram_ready(ram_ready),
	.lane_rd(lane_rd),
	.burst_start(burst_start)
);

// ==== verification/pod_ram_tb.sv ====
////////////////////////////////////////////////////////////
// Pod RAM datapath testbench
// Loads lanes from a case table, drains both outputs and
// compares against a burst-level priority model
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module pod_ram_tb;

	import pod_cfg_pkg::*;
	import ram_req_pkg::*;

	// Per-case cycle budget that also sizes the watchdog
	localparam int case_cycles = 4000;

	logic                      clk_ram_2x;
	logic                      rst;
	logic                      ram_ready;
	lane_req_t                 lane_in [num_lanes];
	logic                      ram_data_rd_en;
	logic [word_bits-1:0]      ram_data_rd_data;
	logic [data_cnt_bits-1:0]  ram_data_rd_size;
	logic                      ram_addr_rd_en;
	ram_addr_t                 ram_addr_rd_data;
	logic [addr_cnt_bits-1:0]  ram_addr_rd_size;

	// Case table
	string               names [$];
	int                  counts [$];
	int                  drains [$];
	int                  n_cases = 0;

	// Model state that persists across cases
	logic [word_bits-1:0]  lane_q [num_lanes][$];
	logic [ptr_bits-1:0]   ptr_model [num_lanes];
	int                    word_idx [num_lanes];
	logic [addr_bits-1:0]  exp_addr [$];
	logic [word_bits-1:0]  exp_data [$];
	int                    errors = 0;
	int                    failed_tests = 0;

	pod_ram_datapath #(
		.pod_number(1)
	) pod_ram_datapath_inst (
		.clk_ram_2x(clk_ram_2x),
		.rst(rst),
		.ram_ready(ram_ready),
		.lane_in(lane_in),
		.ram_data_rd_en(ram_data_rd_en),
		.ram_data_rd_data(ram_data_rd_data),
		.ram_data_rd_size(ram_data_rd_size),
		.ram_addr_rd_en(ram_addr_rd_en),
		.ram_addr_rd_data(ram_addr_rd_data),
		.ram_addr_rd_size(ram_addr_rd_size)
	);

	always #50 clk_ram_2x = ~clk_ram_2x;

	////////////////////////////////////////////////////////////
	// Burst-level model of the arbiter priority rule

	task automatic predict_bursts(output int nb);
		int pick;
		ram_addr_t a;
		nb = 0;
		do begin
			pick = -1;
			for (int k = 0; k < num_lanes; k++)
				if (lane_q[k].size() > lane_half)
					pick = k;
			if (pick < 0)
				for (int k = 0; k < num_lanes; k++)
					if (lane_q[k].size() >= burst_len)
						pick = k;
			if (pick >= 0) begin
				a.fields.valid = 1'b1;
				a.fields.pod   = 1'b1;
				a.fields.lane  = lane_bits'(pick);
				a.fields.ptr   = ptr_model[pick];
				a.fields.pad   = '0;
				exp_addr.push_back(a.raw);
				for (int i = 0; i < burst_len; i++)
					exp_data.push_back(lane_q[pick].pop_front());
				ptr_model[pick] = ptr_model[pick] + 1'b1;
				nb++;
			end
		end while (pick >= 0);
	endtask

	// Load all lanes in parallel with one word per lane per cycle
	task automatic load_lanes(input int base);
		logic [word_bits-1:0] w;
		for (int i = 0; i < lane_depth; i++) begin
			@(posedge clk_ram_2x);
			for (int k = 0; k < num_lanes; k++) begin
				w = {$urandom(), $urandom(), $urandom(), $urandom()};
				// Lane and index in the top bits for easy reading
				w[127:120] = 8'(k);
				w[119:104] = 16'(word_idx[k]);
				lane_in[k].wr   <= (i < counts[base + k]);
				lane_in[k].data <= w;
				if (i < counts[base + k]) begin
					lane_q[k].push_back(w);
					word_idx[k]++;
				end
			end
		end
		@(posedge clk_ram_2x);
		for (int k = 0; k < num_lanes; k++)
			lane_in[k].wr <= 1'b0;
	endtask

	// Pop tasks start and end at a falling edge
	task automatic pop_addr;
		logic [addr_bits-1:0] exp;
		@(posedge clk_ram_2x);
		ram_addr_rd_en <= 1'b1;
		@(posedge clk_ram_2x);
		ram_addr_rd_en <= 1'b0;
		@(negedge clk_ram_2x);
		if (exp_addr.size() == 0) begin
			$display("unexpected extra address word arrived");
			errors++;
		end else begin
			exp = exp_addr.pop_front();
			assert (ram_addr_rd_data.raw == exp) else begin
				$display("[FAIL] ram_addr_rd_data got %h expected %h",
					ram_addr_rd_data.raw, exp);
				errors++;
			end
		end
	endtask

	task automatic pop_data;
		logic [word_bits-1:0] exp;
		@(posedge clk_ram_2x);
		ram_data_rd_en <= 1'b1;
		@(posedge clk_ram_2x);
		ram_data_rd_en <= 1'b0;
		@(negedge clk_ram_2x);
		if (exp_data.size() == 0) begin
			$display("unexpected extra data word arrived");
			errors++;
		end else begin
			exp = exp_data.pop_front();
			assert (ram_data_rd_data == exp) else begin
				$display("[FAIL] ram_data_rd_data got %h expected %h",
					ram_data_rd_data, exp);
				errors++;
			end
		end
	endtask

	task automatic check_sizes(input int exp_d, input int exp_a);
		assert (int'(ram_data_rd_size) == exp_d) else begin
			$display("[FAIL] ram_data_rd_size got %h expected %h", ram_data_rd_size, exp_d);
			errors++;
		end
		assert (int'(ram_addr_rd_size) == exp_a) else begin
			$display("[FAIL] ram_addr_rd_size got %h expected %h", ram_addr_rd_size, exp_a);
			errors++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Case table reader

	task automatic read_cases;
		int fd;
		int c [num_lanes];
		int dr;
		string line;
		string nm;
		fd = $fopen("verification/pod_ram_cases.txt", "r");
		if (fd == 0) begin
			$display("could not open the case table");
			errors++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line.substr(0, 0) == "#")
				continue;
			if ($sscanf(line, "%s %d %d %d %d %d %d %d %d %d", nm, c[0], c[1], c[2],
					c[3], c[4], c[5], c[6], c[7], dr) == 10) begin
				names.push_back(nm);
				for (int k = 0; k < num_lanes; k++)
					counts.push_back(c[k]);
				drains.push_back(dr);
			end
		end
		$fclose(fd);
		n_cases = names.size();
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		int nb;
		int held;
		int spent;
		int errs_before;
		void'($urandom(32'h8489));
		clk_ram_2x     = 1'b0;
		rst            = 1'b1;
		ram_ready      = 1'b0;
		ram_data_rd_en = 1'b0;
		ram_addr_rd_en = 1'b0;
		for (int k = 0; k < num_lanes; k++) begin
			lane_in[k]   = '0;
			ptr_model[k] = '0;
			word_idx[k]  = 0;
		end
		read_cases();
		repeat (10) @(posedge clk_ram_2x);
		rst <= 1'b0;
		@(negedge clk_ram_2x);
		check_sizes(0, 0);

		for (int t = 0; t < n_cases; t++) begin
			errs_before = errors;
			load_lanes(t * num_lanes);
			// Nothing may leave the lanes while disarmed
			repeat (10) @(negedge clk_ram_2x);
			check_sizes(0, 0);
			predict_bursts(nb);
			@(posedge clk_ram_2x);
			ram_ready <= 1'b1;
			if (drains[t] == 0) begin
				// Outputs fill until both FIFOs run out of burst room
				repeat (200) @(negedge clk_ram_2x);
				held = (nb < addr_depth) ? nb : addr_depth;
				check_sizes(held * burst_len, held);
			end
			@(negedge clk_ram_2x);
			spent = 0;
			while ((exp_addr.size() > 0 || exp_data.size() > 0) && spent < case_cycles) begin
				if (ram_addr_rd_size != '0) begin
					pop_addr();
					spent += 2;
				end else if (ram_data_rd_size != '0) begin
					pop_data();
					spent += 2;
				end else begin
					@(negedge clk_ram_2x);
					spent++;
				end
			end
			if (exp_addr.size() > 0 || exp_data.size() > 0) begin
				$display("drain timed out with %0d address and %0d data words missing",
					exp_addr.size(), exp_data.size());
				errors++;
			end
			// Leftover short lanes must not produce anything more
			repeat (20) @(negedge clk_ram_2x);
			check_sizes(0, 0);
			@(posedge clk_ram_2x);
			ram_ready <= 1'b0;
			if (errors == errs_before) begin
				$display("test %s bursts %0d  ok", names[t], nb);
			end else begin
				$display("test %s bursts %0d  %0d errors", names[t], nb, errors - errs_before);
				failed_tests++;
			end
		end

		$display("tests %0d  failed %0d  errors %0d", n_cases, failed_tests, errors);
		if (errors == 0 && n_cases > 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	// Watchdog sized from the case count
	initial begin
		wait (n_cases > 0);
		repeat (n_cases * case_cycles * 2 + 100) @(posedge clk_ram_2x);
		$display("watchdog expired, run did not complete");
		$display("Simulation FAILED");
		$finish;
	end

endmodule

// ==== verification/pod_ram_cases.txt ====
# name  lane0..lane7 word counts  drain (1 drains at once, 0 waits first)
# lane words left below a burst stay in the lane for the next case
reset_idle      0  0  0  0  0  0  0  0  1
single_lane     0  0  4  0  0  0  0  0  1
single_lane7    0  0  0  0  0  0  0  4  1
short_lane      0  3  0  0  0  0  0  0  1
short_topup     0  1  0  0  0  0  0  0  1
prio_half       36 0  0  0  0  0  0  8  1
prio_half_mid   0  0  0  40 0  0  0  12 1
prio_ready      4  8  0  4  0  0  8  0  1
ptr_seq         0  0  0  0  0  16 0  0  1
ptr_mixed       8  0  8  0  8  0  0  0  1
ptr_again       4  4  4  4  4  4  4  4  1
odd_counts      5  6  7  9  10 11 13 2  1
backpress       40 40 20 0  0  0  0  12 0
backpress_half  60 0  0  60 0  0  0  0  0
backpress_small 8  0  0  0  0  0  0  8  0
full_mix        33 33 33 33 33 33 33 33 1
full_hold       33 33 33 33 33 33 33 33 0
tail_only       1  2  3  0  1  2  3  0  1
tail_fill       3  2  1  4  3  2  1  4  1

// ==== src.f ====
common/pod_cfg_pkg.sv
common/ram_req_pkg.sv
logic/sample_fifo.sv
arbiter/burst_arbiter.sv
arbiter/burst_writer.sv
logic/pod_ram_datapath.sv
verification/pod_ram_checker.sv
verification/pod_ram_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the pod RAM datapath testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module pod_ram_tb -o pod_ram_sim \
	&& ./obj_dir/pod_ram_sim > sim.log 2>&1

cat sim.log 2>/dev/null

grep -q "Simulation PASSED" sim.log && echo "run passed" || { echo "run failed"; exit 1; }
